// File: verilog/cpu_pkg.sv
package cpu_pkg;

	// top nibble of every instruction word
	typedef enum logic [3:0] {
		op_add  = 4'h0,
		op_sub  = 4'h1,
		op_xor  = 4'h2,
		// reserved, behaves as a no-op
		op_rsv3 = 4'h3,
		op_sll  = 4'h4,
		op_sra  = 4'h5,
		op_ror  = 4'h6,
		// reserved, behaves as a no-op
		op_rsv7 = 4'h7,
		op_lw   = 4'h8,
		op_sw   = 4'h9,
		op_llb  = 4'ha,
		op_lhb  = 4'hb,
		op_b    = 4'hc,
		op_br   = 4'hd,
		op_pcs  = 4'he,
		op_hlt  = 4'hf
	} opcode_t;

	// branch conditions, bits 11:9 of B and BR
	typedef enum logic [2:0] {
		cond_neq    = 3'd0,
		cond_eq     = 3'd1,
		cond_gt     = 3'd2,
		cond_lt     = 3'd3,
		cond_gte    = 3'd4,
		cond_lte    = 3'd5,
		cond_ovf    = 3'd6,
		cond_always = 3'd7
	} cond_t;

	// bit positions inside the 3-bit flag word
	localparam int flag_z = 0;
	localparam int flag_v = 1;
	localparam int flag_n = 2;

	// register view, also carries imm4 and imm8 in the low bits
	typedef struct packed {
		opcode_t    opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
	} instr_reg_t;

	// branch view, offset counts words
	typedef struct packed {
		opcode_t    opcode;
		cond_t      cond;
		logic [8:0] offset;
	} instr_br_t;

	typedef union packed {
		instr_reg_t r;
		instr_br_t  b;
	} instr_word_t;

endpackage

// File: verilog/memory.sv
`timescale 1ns/10ps

module memory #(
	parameter int addr_width = 8
) (
	input  logic        clk,
	input  logic [15:0] addr,
	input  logic        wr_en,
	input  logic [15:0] wr_data,
	output logic [15:0] rd_data
);

	localparam int depth = 2 ** addr_width;

	logic [15:0]           mem [depth];
	logic [addr_width-1:0] word_idx;

	// byte address to word index, upper bits wrap
	assign word_idx = addr[addr_width:1];

	// contents survive reset
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[word_idx] <= wr_data;
	end

	// async read, same cycle as the address
	assign rd_data = mem[word_idx];

endmodule

// File: verilog/alu.sv
`timescale 1ns/10ps

module alu (
	input  cpu_pkg::opcode_t op,
	input  logic [15:0]      a,
	input  logic [15:0]      b,
	output logic [15:0]      result,
	output logic [2:0]       flags_new,
	output logic [2:0]       flag_wen
);

	import cpu_pkg::*;

	logic [15:0] sum;
	logic [15:0] diff;
	logic        add_ovf;
	logic        sub_ovf;
	logic        ovf;
	logic [31:0] rot;

	assign sum  = a + b;
	assign diff = a - b;

	// signed overflow, operands agree in sign but result does not
	assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
	// for sub the operands must differ in sign
	assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

	// rotate by shifting a doubled copy
	assign rot = {a, a} >> b[3:0];

	always_comb begin
		result   = 16'h0000;
		ovf      = 1'b0;
		flag_wen = 3'b000;
		case (op)
			op_add: begin
				flag_wen = 3'b111;
				ovf      = add_ovf;
				// clamp toward the sign of the operands
				if (add_ovf)
					result = a[15] ? 16'h8000 : 16'h7fff;
				else
					result = sum;
			end
			op_sub: begin
				flag_wen = 3'b111;
				ovf      = sub_ovf;
				if (sub_ovf)
					result = a[15] ? 16'h8000 : 16'h7fff;
				else
					result = diff;
			end
			op_xor: begin
				flag_wen[flag_z] = 1'b1;
				result           = a ^ b;
			end
			op_sll: begin
				flag_wen[flag_z] = 1'b1;
				result           = a << b[3:0];
			end
			op_sra: begin
				flag_wen[flag_z] = 1'b1;
				result           = $signed(a) >>> b[3:0];
			end
			op_ror: begin
				flag_wen[flag_z] = 1'b1;
				result           = rot[15:0];
			end
			default: ;
		endcase
	end

	// flags follow the final, possibly clamped result
	assign flags_new[flag_z] = (result == 16'h0000);
	assign flags_new[flag_v] = ovf;
	assign flags_new[flag_n] = result[15];

endmodule

// File: verilog/register_file.sv
`timescale 1ns/10ps

module register_file (
	input  logic        clk,
	input  logic        reset,
	input  logic [3:0]  rd_sel1,
	input  logic [3:0]  rd_sel2,
	input  logic [3:0]  dbg_sel,
	input  logic [3:0]  wr_sel,
	input  logic        wr_en,
	input  logic [15:0] wr_data,
	output logic [15:0] rd_data1,
	output logic [15:0] rd_data2,
	output logic [15:0] dbg_data
);

	logic [15:0] regs [16];

	// r0 never takes a write
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= 16'h0000;
		end else if (wr_en && (wr_sel != 4'd0)) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// r0 reads as zero because reset clears it and writes skip it
	// no write bypass so a new value shows after the edge
	assign rd_data1 = regs[rd_sel1];
	assign rd_data2 = regs[rd_sel2];
	// debug read for the testbench
	assign dbg_data = regs[dbg_sel];

endmodule

// File: verilog/control_unit.sv
`timescale 1ns/10ps

module control_unit (
	input  cpu_pkg::instr_word_t instr,
	output logic               reg_write,
	output logic               mem_read,
	output logic               mem_write,
	output logic               mem_to_reg,
	output logic               alu_src_imm,
	output logic               alu_op_sel,
	output logic               pcs,
	output logic               top_half,
	output logic               halt
);

	import cpu_pkg::*;

	always_comb begin
		// everything off, reserved opcodes stay here
		reg_write   = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		mem_to_reg  = 1'b0;
		alu_src_imm = 1'b0;
		alu_op_sel  = 1'b0;
		pcs         = 1'b0;
		top_half    = 1'b0;
		halt        = 1'b0;
		case (instr.r.opcode)
			op_add, op_sub, op_xor: begin
				reg_write  = 1'b1;
				alu_op_sel = 1'b1;
			end
			// shift count is the imm4 field
			op_sll, op_sra, op_ror: begin
				reg_write   = 1'b1;
				alu_op_sel  = 1'b1;
				alu_src_imm = 1'b1;
			end
			op_lw: begin
				reg_write   = 1'b1;
				mem_read    = 1'b1;
				mem_to_reg  = 1'b1;
				alu_src_imm = 1'b1;
			end
			op_sw: begin
				mem_write   = 1'b1;
				alu_src_imm = 1'b1;
			end
			op_llb: reg_write = 1'b1;
			op_lhb: begin
				reg_write = 1'b1;
				top_half  = 1'b1;
			end
			op_pcs: begin
				reg_write = 1'b1;
				pcs       = 1'b1;
			end
			op_hlt: halt = 1'b1;
			// B, BR and reserved opcodes need no datapath control
			default: ;
		endcase
	end

endmodule

// File: verilog/pc_unit.sv
`timescale 1ns/10ps

module pc_unit (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::instr_word_t instr,
	input  logic               halt,
	input  logic [2:0]         flags_new,
	input  logic [2:0]         flag_wen,
	input  logic [15:0]        branch_target_reg,
	output logic [15:0]        pc
);

	import cpu_pkg::*;

	logic [2:0]  flags;
	logic        taken;
	logic [15:0] pc_plus2;
	logic [15:0] b_target;
	logic [15:0] pc_next;

	assign pc_plus2 = pc + 16'd2;
	// offset is in words, so shift left by one
	assign b_target = pc_plus2 + {{6{instr.b.offset[8]}}, instr.b.offset, 1'b0};

	// condition against the flags held before this instruction
	always_comb begin
		case (instr.b.cond)
			cond_neq: taken = ~flags[flag_z];
			cond_eq:  taken = flags[flag_z];
			cond_gt:  taken = ~flags[flag_z] & ~flags[flag_n];
			cond_lt:  taken = flags[flag_n];
			cond_gte: taken = flags[flag_z] | ~flags[flag_n];
			cond_lte: taken = flags[flag_n] | flags[flag_z];
			cond_ovf: taken = flags[flag_v];
			default:  taken = 1'b1;
		endcase
	end

	always_comb begin
		pc_next = pc_plus2;
		// halt parks the pc on the HLT word
		if (halt)
			pc_next = pc;
		else if ((instr.b.opcode == op_b) && taken)
			pc_next = b_target;
		else if ((instr.b.opcode == op_br) && taken)
			pc_next = branch_target_reg;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= 16'h0000;
		else
			pc <= pc_next;
	end

	// each flag bit has its own write enable
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= 3'b000;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (flag_wen[i])
					flags[i] <= flags_new[i];
			end
		end
	end

endmodule

// File: verilog/cpu.sv
`timescale 1ns/10ps

module cpu #(
	parameter int imem_addr_width = 8,
	parameter int dmem_addr_width = 8
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        load_en,
	input  logic [15:0] load_addr,
	input  logic [15:0] load_data,
	input  logic [3:0]  dbg_sel,
	output logic [15:0] dbg_data,
	output logic        hlt,
	output logic [15:0] pc
);

	import cpu_pkg::*;

	// current instruction, decoded through the union everywhere
	instr_word_t instr;

	// control
	logic reg_write;
	logic mem_read;
	logic mem_write;
	logic mem_to_reg;
	logic alu_src_imm;
	logic alu_op_sel;
	logic pcs;
	logic top_half;
	logic halt;

	// register file side
	logic [3:0]  rd_sel1;
	logic [3:0]  rd_sel2;
	logic [15:0] rd_data1;
	logic [15:0] rd_data2;
	logic [15:0] wb_data;
	logic        reg_wr_en;

	// alu side
	logic [15:0] imm_sext;
	logic [15:0] alu_b;
	logic [15:0] alu_result;
	logic [2:0]  flags_new;
	logic [2:0]  flag_wen;

	// memories
	logic [15:0] imem_addr;
	logic        imem_wr_en;
	logic [15:0] dmem_addr;
	logic [15:0] dmem_rd_data;
	logic [15:0] mem_word;
	logic        dmem_wr_en;

	logic [15:0] pcs_sum;
	logic [7:0]  byte_imm;
	logic        byte_load;

	// load port only reaches the imem while the core is held
	assign imem_wr_en = load_en & reset;
	assign imem_addr  = reset ? load_addr : pc;

	// no architectural writes during reset
	assign reg_wr_en  = reg_write & ~reset;
	assign dmem_wr_en = mem_write & ~reset;

	// LLB/LHB read their own destination for the byte merge
	assign byte_load = (instr.r.opcode == op_llb) || (instr.r.opcode == op_lhb);
	assign rd_sel1   = byte_load ? instr.r.rd : instr.r.rs;
	// SW stores rd
	assign rd_sel2   = mem_write ? instr.r.rd : instr.r.rt;

	assign imm_sext = {{12{instr.r.rt[3]}}, instr.r.rt};
	assign alu_b    = alu_src_imm ? imm_sext : rd_data2;
	assign byte_imm = {instr.r.rs, instr.r.rt};

	// base register plus signed offset, byte address
	assign dmem_addr = rd_data1 + imm_sext;
	assign mem_word  = mem_read ? dmem_rd_data : 16'h0000;

	assign pcs_sum = pc + 16'd2;

	// write-back select, fixed priority
	always_comb begin
		if (pcs)
			wb_data = pcs_sum;
		else if (mem_to_reg)
			wb_data = mem_word;
		else if (alu_op_sel)
			wb_data = alu_result;
		else if (top_half)
			wb_data = {byte_imm, rd_data1[7:0]};
		else
			wb_data = {rd_data1[15:8], byte_imm};
	end

	assign hlt = halt;

	pc_unit i_pc_unit (
		.clk               (clk),
		.reset             (reset),
		.instr             (instr),
		.halt              (halt),
		.flags_new         (flags_new),
		.flag_wen          (flag_wen),
		.branch_target_reg (rd_data1),
		.pc                (pc)
	);

	control_unit i_control_unit (
		.instr       (instr),
		.reg_write   (reg_write),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_to_reg  (mem_to_reg),
		.alu_src_imm (alu_src_imm),
		.alu_op_sel  (alu_op_sel),
		.pcs         (pcs),
		.top_half    (top_half),
		.halt        (halt)
	);

	register_file i_register_file (
		.clk      (clk),
		.reset    (reset),
		.rd_sel1  (rd_sel1),
		.rd_sel2  (rd_sel2),
		.dbg_sel  (dbg_sel),
		.wr_sel   (instr.r.rd),
		.wr_en    (reg_wr_en),
		.wr_data  (wb_data),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.dbg_data (dbg_data)
	);

	alu i_alu (
		.op        (instr.r.opcode),
		.a         (rd_data1),
		.b         (alu_b),
		.result    (alu_result),
		.flags_new (flags_new),
		.flag_wen  (flag_wen)
	);

	memory #(.addr_width(imem_addr_width)) i_imem (
		.clk     (clk),
		.addr    (imem_addr),
		.wr_en   (imem_wr_en),
		.wr_data (load_data),
		.rd_data (instr)
	);

	memory #(.addr_width(dmem_addr_width)) i_dmem (
		.clk     (clk),
		.addr    (dmem_addr),
		.wr_en   (dmem_wr_en),
		.wr_data (rd_data2),
		.rd_data (dmem_rd_data)
	);

endmodule

// File: test/cpu_sva.sv
`timescale 1ns/10ps

module cpu_sva (
	input logic        clk,
	input logic        reset,
	input logic        hlt,
	input logic [15:0] pc
);

	// once halted the core stays halted until reset
	property hlt_holds;
		@(posedge clk) (hlt && !reset) |=> (hlt || reset);
	endproperty

	// the pc is parked on the HLT word
	property pc_parked;
		@(posedge clk) (hlt && !reset) |=> $stable(pc);
	endproperty

	// instructions are word aligned
	property pc_even;
		@(posedge clk) disable iff (reset) (pc[0] == 1'b0);
	endproperty

	property pc_cleared;
		@(posedge clk) reset |=> (pc == 16'h0000);
	endproperty

	a_hlt_holds:  assert property (hlt_holds)  else $error("hlt dropped without reset");
	a_pc_parked:  assert property (pc_parked)  else $error("pc moved while halted");
	a_pc_even:    assert property (pc_even)    else $error("pc is odd");
	a_pc_cleared: assert property (pc_cleared) else $error("pc not zero after reset");

endmodule

// File: test/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

	logic        clk;
	logic        reset;
	logic        load_en;
	logic [15:0] load_addr;
	logic [15:0] load_data;
	logic [3:0]  dbg_sel;
	logic [15:0] dbg_data;
	logic        hlt;
	logic [15:0] pc;

	// program and expected registers of the test being parsed
	logic [15:0] prog_addr [$];
	logic [15:0] prog_word [$];
	logic [3:0]  exp_reg [$];
	logic [15:0] exp_val [$];

	string test_name;
	int    value_errors;
	int    timeout_errors;
	int    format_errors;
	int    tests_run;

	cpu #(
		.imem_addr_width (8),
		.dmem_addr_width (8)
	) i_dut (
		.clk       (clk),
		.reset     (reset),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.dbg_sel   (dbg_sel),
		.dbg_data  (dbg_data),
		.hlt       (hlt),
		.pc        (pc)
	);

	bind cpu cpu_sva i_cpu_sva (
		.clk   (clk),
		.reset (reset),
		.hlt   (hlt),
		.pc    (pc)
	);

	initial clk = 1'b0;
	// 100 ns period
	always #50 clk = ~clk;

	// hold the core in reset and push the program through the load port
	task automatic reset_and_load();
		int i;
		int n_cycles;
		n_cycles = (prog_word.size() > 16) ? prog_word.size() : 16;
		for (i = 0; i < n_cycles; i++) begin
			@(negedge clk);
			reset = 1'b1;
			if (i < prog_word.size()) begin
				load_en   = 1'b1;
				load_addr = prog_addr[i];
				load_data = prog_word[i];
			end else begin
				load_en = 1'b0;
			end
		end
		@(negedge clk);
		reset     = 1'b0;
		load_en   = 1'b0;
		load_addr = 16'h0000;
		load_data = 16'h0000;
	endtask

	// hlt is sampled mid cycle, away from the rising edge
	task automatic wait_for_halt(input int limit, output bit reached);
		int cycles;
		reached = 1'b0;
		cycles  = 0;
		while (!reached && (cycles < limit)) begin
			@(negedge clk);
			cycles++;
			if (hlt === 1'b1)
				reached = 1'b1;
		end
	endtask

	task automatic run_test(input logic [15:0] halt_pc, input int limit);
		bit reached;
		int i;
		reset_and_load();
		wait_for_halt(limit, reached);
		if (!reached) begin
			$display("test %0s: halt not reached within %0d cycles", test_name, limit);
			timeout_errors++;
		end else begin
			for (i = 0; i < exp_reg.size(); i++) begin
				@(negedge clk);
				dbg_sel = exp_reg[i];
				#10;
				if (dbg_data !== exp_val[i]) begin
					$display("error %0s r%0d expected %h actual %h",
						test_name, exp_reg[i], exp_val[i], dbg_data);
					value_errors++;
				end
			end
			if (pc !== halt_pc) begin
				$display("error %0s halt pc expected %h actual %h", test_name, halt_pc, pc);
				value_errors++;
			end
		end
		tests_run++;
	endtask

	initial begin
		int               fd;
		int               n;
		int               limit;
		int               reg_idx;
		bit               done;
		logic [15:0]      addr_val;
		logic [15:0]      word_val;
		logic [8*24-1:0]  tok;
		logic [8*160-1:0] line;
		string            tok_s;

		reset     = 1'b1;
		load_en   = 1'b0;
		load_addr = 16'h0000;
		load_data = 16'h0000;
		dbg_sel   = 4'd0;

		value_errors   = 0;
		timeout_errors = 0;
		format_errors  = 0;
		tests_run      = 0;
		test_name      = "none";
		done           = 1'b0;

		fd = $fopen("test/cpu_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open test/cpu_stimulus.txt");
			format_errors++;
			done = 1'b1;
		end
		while (!done) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1) begin
				done = 1'b1;
			end else begin
				tok_s = string'(tok);
				if (tok_s == "#") begin
					// rest of the line is a comment
					n = $fgets(line, fd);
				end else if (tok_s == "test") begin
					n = $fscanf(fd, "%s", tok);
					test_name = string'(tok);
					prog_addr.delete();
					prog_word.delete();
					exp_reg.delete();
					exp_val.delete();
				end else if (tok_s == "prog") begin
					n = $fscanf(fd, "%h %h", addr_val, word_val);
					if (n != 2) begin
						$display("bad program line in test %0s", test_name);
						format_errors++;
					end
					prog_addr.push_back(addr_val);
					prog_word.push_back(word_val);
				end else if (tok_s == "reg") begin
					n = $fscanf(fd, "%d %h", reg_idx, word_val);
					if (n != 2) begin
						$display("bad register line in test %0s", test_name);
						format_errors++;
					end
					exp_reg.push_back(reg_idx[3:0]);
					exp_val.push_back(word_val);
				end else if (tok_s == "halt") begin
					// the halt line closes a test and starts it
					n = $fscanf(fd, "%h %d", addr_val, limit);
					if (n != 2) begin
						$display("bad halt line in test %0s", test_name);
						format_errors++;
					end else begin
						run_test(addr_val, limit);
					end
				end else begin
					$display("unknown word %0s in stimulus file", tok_s);
					format_errors++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("%0d tests run, %0d value errors, %0d timeouts, %0d stimulus errors",
			tests_run, value_errors, timeout_errors, format_errors);
		if ((value_errors + timeout_errors + format_errors == 0) && (tests_run > 0)) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: test/cpu_stimulus.txt
# test <name> | prog <byte addr> <word> | reg <index> <value>
# halt <halt pc> <cycle limit> closes a test and runs it, all values hex except index and limit
test arith_logic
prog 0000 a134
prog 0002 b112
prog 0004 a2ff
prog 0006 b27f
prog 0008 0312
prog 000a 1421
prog 000c a500
prog 000e b580
prog 0010 1651
prog 0012 0711
prog 0014 2812
prog 0016 4914
prog 0018 5a53
prog 001a 6b14
prog 001c 0011
prog 001e f000
reg 0 0000
reg 1 1234
reg 2 7fff
reg 3 7fff
reg 4 6dcb
reg 5 8000
reg 6 8000
reg 7 2468
reg 8 6dcb
reg 9 2340
reg 10 f000
reg 11 4123
halt 001e 40
test memory_pcs_br
prog 0000 a140
prog 0002 a255
prog 0004 9212
prog 0006 a3aa
prog 0008 931e
prog 000a 8412
prog 000c 851e
prog 000e e600
prog 0010 a808
prog 0012 0768
prog 0014 de70
prog 0016 a911
prog 0018 aa22
prog 001a 3b11
prog 001c f000
reg 1 0040
reg 2 0055
reg 3 00aa
reg 4 0055
reg 5 00aa
reg 6 0010
reg 7 0018
reg 8 0008
reg 9 0000
reg 10 0022
reg 11 0000
halt 001c 40
test branches
prog 0000 a105
prog 0002 a207
prog 0004 1312
prog 0006 2412
prog 0008 c601
prog 000a a511
prog 000c c401
prog 000e a622
prog 0010 0711
prog 0012 c801
prog 0014 a833
prog 0016 1911
prog 0018 c001
prog 001a aa44
prog 001c cc01
prog 001e f000
reg 3 fffe
reg 4 0002
reg 5 0000
reg 6 0022
reg 7 000a
reg 8 0000
reg 9 0000
reg 10 0044
halt 001e 40

// File: files.f
verilog/cpu_pkg.sv
verilog/memory.sv
verilog/alu.sv
verilog/register_file.sv
verilog/control_unit.sv
verilog/pc_unit.sv
verilog/cpu.sv
test/cpu_sva.sv
test/cpu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpu_tb
FILELIST  = files.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir
